// ==== files.f ====
verilog/mem_pkg.sv
verilog/mem_2rw.sv
verilog/mem_1r1w_pipelined.sv
verilog/core_port_ctrl.sv
verilog/core_mem_top.sv
test/tb_check.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run by the pass line in the output
verilator --binary --timing --assert -j 0 --top-module tb_top -f files.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }

// ==== test/tb_top.sv ====
// testbench for core_mem_top, six directed-random tests in sequence
// inputs change on the falling edge, tb_check compares against its models
// core writes stay in the lower half and DMA in the upper half in mixed traffic
// run ends on a cycle limit derived from the test lengths

`timescale 1ns/1ps

module tb_top import mem_pkg::*; ();

  localparam int N_CORE   = 48;
  localparam int N_DMA    = 32;
  localparam int N_LOOKUP = 64;
  localparam int N_RANGE  = 16;
  localparam int N_MIXED  = 200;
  localparam int DRAIN    = 6;
  localparam int T_TOTAL  = 2 + 20 + 2 * N_CORE + 2 * N_DMA + TBL_DEPTH + N_LOOKUP
                            + 2 * N_RANGE + N_MIXED + 6 * (DRAIN + 1);
  localparam int MAX_CYCLES = T_TOTAL + 50;

  logic clk = 1'b0;
  logic rst;
  core_op_t                  core_op;
  logic [ADDR_WIDTH-1:0]     core_addr;
  logic [LINE_SIZE-1:0]      core_wdata;
  logic [BYTES_PER_LINE-1:0] core_be;
  logic [LINE_SIZE-1:0]      core_rd_data;
  logic                      core_rd_valid;
  logic [LINE_SIZE-1:0]      core_lk_data;
  logic                      core_lk_valid;
  logic                      core_err;
  logic                      dma_en;
  logic [BYTES_PER_LINE-1:0] dma_be;
  logic [ADDR_WIDTH-1:0]     dma_addr;
  logic [LINE_SIZE-1:0]      dma_wdata;
  logic [LINE_SIZE-1:0]      dma_rd_data;
  logic                      dma_rd_valid;
  logic                      dma_tbl_wr;
  logic [TBL_ADDR_WIDTH-1:0] dma_tbl_addr;
  logic [LINE_SIZE-1:0]      dma_tbl_data;
  int error_count;

  logic [31:0] lfsr = 32'haa20;
  logic [ADDR_WIDTH-1:0] addr_list [64];
  int cycles = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int err_mark = 0;

  core_mem_top i_dut (.*);
  tb_check i_check (.*);

  always #50 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] rand_addr();
    logic [31:0] r;
    r = take_bits(ADDR_WIDTH);
    return r[ADDR_WIDTH-1:0];
  endfunction

  function automatic logic [BYTES_PER_LINE-1:0] rand_be();
    logic [31:0] r;
    r = take_bits(BYTES_PER_LINE);
    return r[BYTES_PER_LINE-1:0];
  endfunction

  task automatic drive_idle();
    core_op      = OP_NOP;
    core_addr    = '0;
    core_wdata   = '0;
    core_be      = '0;
    dma_en       = 1'b0;
    dma_be       = '0;
    dma_addr     = '0;
    dma_wdata    = '0;
    dma_tbl_wr   = 1'b0;
    dma_tbl_addr = '0;
    dma_tbl_data = '0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    drive_idle();
  endtask

  // let reads drain, then one result line
  task automatic finish_test(string name);
    repeat (DRAIN) next_cycle();
    @(posedge clk);
    tests_run++;
    if (error_count == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d mismatches", tests_run, name, error_count - err_mark);
    end
    err_mark = error_count;
  endtask

  task automatic idle_then_read_zero();
    // outputs idle, then unwritten words read back as zero
    repeat (4) next_cycle();
    for (int i = 0; i < 16; i++) begin
      next_cycle();
      core_op   = OP_READ;
      core_addr = rand_addr();
    end
  endtask

  task automatic core_write_read();
    for (int i = 0; i < N_CORE; i++) begin
      next_cycle();
      addr_list[i] = rand_addr();
      core_op    = OP_WRITE;
      core_addr  = addr_list[i];
      core_wdata = take_bits(LINE_SIZE);
      core_be    = rand_be();
    end
    for (int i = 0; i < N_CORE; i++) begin
      next_cycle();
      core_op   = OP_READ;
      core_addr = addr_list[i];
    end
  endtask

  task automatic dma_write_cross_read();
    for (int i = 0; i < N_DMA; i++) begin
      next_cycle();
      addr_list[i] = rand_addr();
      dma_en    = 1'b1;
      dma_be    = rand_be();
      dma_addr  = addr_list[i];
      dma_wdata = take_bits(LINE_SIZE);
    end
    // both ports read, nothing written meanwhile
    for (int i = 0; i < N_DMA; i++) begin
      next_cycle();
      dma_en    = 1'b1;
      dma_addr  = addr_list[i];
      core_op   = OP_READ;
      core_addr = addr_list[i];
    end
  endtask

  task automatic fill_and_lookup();
    logic [ADDR_WIDTH-1:0] a;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      next_cycle();
      dma_tbl_wr   = 1'b1;
      dma_tbl_addr = TBL_ADDR_WIDTH'(i);
      dma_tbl_data = take_bits(LINE_SIZE);
    end
    for (int i = 0; i < N_LOOKUP; i++) begin
      next_cycle();
      a = rand_addr();
      a[ADDR_WIDTH-1:TBL_ADDR_WIDTH] = '0;
      core_op   = OP_LOOKUP;
      core_addr = a;
    end
  endtask

  task automatic out_of_range_lookups();
    logic [ADDR_WIDTH-1:0] a;
    for (int i = 0; i < N_RANGE; i++) begin
      next_cycle();
      a = rand_addr();
      if (int'(a) < TBL_DEPTH)
        a[TBL_ADDR_WIDTH] = 1'b1;
      core_op   = OP_LOOKUP;
      core_addr = a;
      next_cycle();
    end
  endtask

  task automatic mixed_traffic();
    logic [31:0] r;
    logic [ADDR_WIDTH-1:0] a;
    for (int i = 0; i < N_MIXED; i++) begin
      next_cycle();
      r = take_bits(2);
      core_op = core_op_t'(r[1:0]);
      a = rand_addr();
      // core scratchpad traffic in the lower half
      if (core_op != OP_LOOKUP)
        a[ADDR_WIDTH-1] = 1'b0;
      core_addr  = a;
      core_wdata = take_bits(LINE_SIZE);
      core_be    = rand_be();
      r = take_bits(1);
      dma_en = r[0];
      dma_be = rand_be();
      a = rand_addr();
      a[ADDR_WIDTH-1] = 1'b1;
      dma_addr  = a;
      dma_wdata = take_bits(LINE_SIZE);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    drive_idle();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_then_read_zero();
    finish_test("reset");
    core_write_read();
    finish_test("core port");
    dma_write_cross_read();
    finish_test("dma port");
    fill_and_lookup();
    finish_test("lookups");
    out_of_range_lookups();
    finish_test("range errors");
    mixed_traffic();
    finish_test("mixed traffic");
    $display("%0d tests run, %0d with mismatches, %0d mismatches in all",
             tests_run, tests_bad, error_count);
    if (tests_bad == 0 && error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== test/tb_check.sv ====
// reference model and scoreboard for core_mem_top
// requests sampled at the rising edge, outputs compared at the falling edge
// models are read-first, stimulus keeps same-cycle cross-port hits out
// model contents are cleared while rst is high, matching the zeroed DUT arrays

`timescale 1ns/1ps

module tb_check import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  core_op_t                  core_op,
  input  logic [ADDR_WIDTH-1:0]     core_addr,
  input  logic [LINE_SIZE-1:0]      core_wdata,
  input  logic [BYTES_PER_LINE-1:0] core_be,
  input  logic [LINE_SIZE-1:0]      core_rd_data,
  input  logic                      core_rd_valid,
  input  logic [LINE_SIZE-1:0]      core_lk_data,
  input  logic                      core_lk_valid,
  input  logic                      core_err,
  input  logic                      dma_en,
  input  logic [BYTES_PER_LINE-1:0] dma_be,
  input  logic [ADDR_WIDTH-1:0]     dma_addr,
  input  logic [LINE_SIZE-1:0]      dma_wdata,
  input  logic [LINE_SIZE-1:0]      dma_rd_data,
  input  logic                      dma_rd_valid,
  input  logic                      dma_tbl_wr,
  input  logic [TBL_ADDR_WIDTH-1:0] dma_tbl_addr,
  input  logic [LINE_SIZE-1:0]      dma_tbl_data,
  output int                        error_count
);

  logic [LINE_SIZE-1:0] sp_model [SP_DEPTH];
  logic [LINE_SIZE-1:0] tbl_model [TBL_DEPTH];

  // expected results, oldest first
  logic [LINE_SIZE-1:0] rd_q [$];
  logic [LINE_SIZE-1:0] dma_q [$];
  logic [LINE_SIZE-1:0] lk_q [$];

  // expected valid and error levels for the coming half cycle
  logic exp_rd;
  logic exp_dma;
  logic exp_err;
  logic in_range;
  logic lk_req;
  logic [RAM_PIPELINE:0] lk_sh;
  logic active = 1'b0;
  int   errors = 0;

  assign error_count = errors;

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(string what, logic [LINE_SIZE-1:0] got, logic [LINE_SIZE-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < SP_DEPTH; k++)
        sp_model[k] = '0;
      for (int k = 0; k < TBL_DEPTH; k++)
        tbl_model[k] = '0;
      rd_q.delete();
      dma_q.delete();
      lk_q.delete();
      exp_rd  = 1'b0;
      exp_dma = 1'b0;
      exp_err = 1'b0;
      lk_sh   = '0;
      active  = 1'b0;
    end else begin
      active = 1'b1;
      // reads see the contents from before this edge
      exp_rd = (core_op == OP_READ);
      if (exp_rd)
        rd_q.push_back(sp_model[core_addr]);
      // DMA with no lanes set is a read
      exp_dma = dma_en && (dma_be == '0);
      if (exp_dma)
        dma_q.push_back(sp_model[dma_addr]);
      in_range = int'(core_addr) < TBL_DEPTH;
      exp_err  = (core_op == OP_LOOKUP) && !in_range;
      lk_req   = (core_op == OP_LOOKUP) && in_range;
      if (lk_req)
        lk_q.push_back(tbl_model[core_addr[TBL_ADDR_WIDTH-1:0]]);
      // lookup result due RAM_PIPELINE + 1 edges later
      lk_sh = {lk_sh[RAM_PIPELINE-1:0], lk_req};
      // byte lanes, each port only its enabled bytes
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (core_op == OP_WRITE && core_be[i])
          sp_model[core_addr][i*8 +: 8] = core_wdata[i*8 +: 8];
        if (dma_en && dma_be[i])
          sp_model[dma_addr][i*8 +: 8] = dma_wdata[i*8 +: 8];
      end
      if (dma_tbl_wr)
        tbl_model[dma_tbl_addr] = dma_tbl_data;
    end
  end

  // registered outputs are settled by the falling edge
  always @(negedge clk) begin
    if (active) begin
      check_bit("core_rd_valid", core_rd_valid, exp_rd);
      if (exp_rd)
        check_word("core_rd_data", core_rd_data, rd_q.pop_front());
      check_bit("dma_rd_valid", dma_rd_valid, exp_dma);
      if (exp_dma)
        check_word("dma_rd_data", dma_rd_data, dma_q.pop_front());
      check_bit("core_lk_valid", core_lk_valid, lk_sh[RAM_PIPELINE]);
      if (lk_sh[RAM_PIPELINE])
        check_word("core_lk_data", core_lk_data, lk_q.pop_front());
      check_bit("core_err", core_err, exp_err);
    end
  end

endmodule

// ==== verilog/core_mem_top.sv ====
// local memory block of one packet-processing core
// core drives scratchpad port A and the table read port through the decoder
// DMA drives scratchpad port B directly and owns the table write port
// no arbitration, each port has its own master
// DMA read is dma_en with dma_be zero, any set lane makes it a write

`timescale 1ns/1ps

module core_mem_top import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,

  // core side
  input  core_op_t                  core_op,
  input  logic [ADDR_WIDTH-1:0]     core_addr,
  input  logic [LINE_SIZE-1:0]      core_wdata,
  input  logic [BYTES_PER_LINE-1:0] core_be,
  output logic [LINE_SIZE-1:0]      core_rd_data,
  output logic                      core_rd_valid,
  output logic [LINE_SIZE-1:0]      core_lk_data,
  output logic                      core_lk_valid,
  output logic                      core_err,

  // DMA side
  input  logic                      dma_en,
  input  logic [BYTES_PER_LINE-1:0] dma_be,
  input  logic [ADDR_WIDTH-1:0]     dma_addr,
  input  logic [LINE_SIZE-1:0]      dma_wdata,
  output logic [LINE_SIZE-1:0]      dma_rd_data,
  output logic                      dma_rd_valid,
  input  logic                      dma_tbl_wr,
  input  logic [TBL_ADDR_WIDTH-1:0] dma_tbl_addr,
  input  logic [LINE_SIZE-1:0]      dma_tbl_data
);

  // decoder to scratchpad port A
  logic                      sp_en;
  logic [BYTES_PER_LINE-1:0] sp_we;
  logic [ADDR_WIDTH-1:0]     sp_addr;
  logic [LINE_SIZE-1:0]      sp_wdata;

  // decoder to table read port
  logic                      tbl_rd;
  logic [TBL_ADDR_WIDTH-1:0] tbl_addr;

  core_port_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_op    (core_op),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_be    (core_be),
    .sp_en      (sp_en),
    .sp_we      (sp_we),
    .sp_addr    (sp_addr),
    .sp_wdata   (sp_wdata),
    .tbl_rd     (tbl_rd),
    .tbl_addr   (tbl_addr),
    .core_err   (core_err)
  );

  // port A core, port B DMA
  mem_2rw i_scratch (
    .clk     (clk),
    .rst     (rst),
    .ena     (sp_en),
    .wena    (sp_we),
    .addra   (sp_addr),
    .dina    (sp_wdata),
    .douta   (core_rd_data),
    .rvalida (core_rd_valid),
    .enb     (dma_en),
    .wenb    (dma_be),
    .addrb   (dma_addr),
    .dinb    (dma_wdata),
    .doutb   (dma_rd_data),
    .rvalidb (dma_rd_valid)
  );

  // DMA fills, core looks up
  mem_1r1w_pipelined i_table (
    .clk         (clk),
    .rst         (rst),
    .ena         (dma_tbl_wr),
    .addra       (dma_tbl_addr),
    .dina        (dma_tbl_data),
    .enb         (tbl_rd),
    .addrb       (tbl_addr),
    .doutb       (core_lk_data),
    .doutb_valid (core_lk_valid)
  );

endmodule

// ==== verilog/core_port_ctrl.sv ====
// core port decoder for the scratchpad and the lookup table
// scratchpad and table controls are combinational from the opcode
// a write with no byte enables does nothing, it is never turned into a read
// lookups at or above the table size raise core_err one cycle later
// and never reach the table

`timescale 1ns/1ps

module core_port_ctrl import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,

  input  core_op_t                  core_op,
  input  logic [ADDR_WIDTH-1:0]     core_addr,
  input  logic [LINE_SIZE-1:0]      core_wdata,
  input  logic [BYTES_PER_LINE-1:0] core_be,

  // scratchpad port A
  output logic                      sp_en,
  output logic [BYTES_PER_LINE-1:0] sp_we,
  output logic [ADDR_WIDTH-1:0]     sp_addr,
  output logic [LINE_SIZE-1:0]      sp_wdata,

  // table read port
  output logic                      tbl_rd,
  output logic [TBL_ADDR_WIDTH-1:0] tbl_addr,

  output logic                      core_err
);

  // address fits the table when all upper bits are clear
  logic tbl_hit;
  logic err_q;

  assign tbl_hit = (core_addr[ADDR_WIDTH-1:TBL_ADDR_WIDTH] == '0);

  // address and data go straight through, enables decide the access
  assign sp_addr  = core_addr;
  assign sp_wdata = core_wdata;
  assign tbl_addr = core_addr[TBL_ADDR_WIDTH-1:0];

  always_comb begin
    sp_en  = 1'b0;
    sp_we  = '0;
    tbl_rd = 1'b0;
    case (core_op)
      OP_READ: begin
        // no lanes enabled, the scratchpad reads
        sp_en = 1'b1;
      end
      OP_WRITE: begin
        // empty byte mask is dropped here
        if (core_be != '0) begin
          sp_en = 1'b1;
          sp_we = core_be;
        end
      end
      OP_LOOKUP: begin
        tbl_rd = tbl_hit;
      end
      default: begin
        // OP_NOP, nothing issued
      end
    endcase
  end

  // one-cycle error pulse for an out-of-range lookup
  always_ff @(posedge clk) begin
    if (rst)
      err_q <= 1'b0;
    else
      err_q <= (core_op == OP_LOOKUP) && !tbl_hit;
  end

  assign core_err = err_q;

  // opcode must be a defined value outside reset
  a_op_legal : assert property (
    @(posedge clk) disable iff (rst)
    core_op inside {OP_NOP, OP_READ, OP_WRITE, OP_LOOKUP}
  ) else $error("illegal core opcode %0h", core_op);

endmodule

// ==== verilog/mem_1r1w_pipelined.sv ====
// single-write single-read lookup table with a pipelined read path
// writes replace the whole word at the sampling edge
// read register plus RAM_PIPELINE output stages, RAM_PIPELINE + 1 cycle latency
// a read of a word written at the same edge returns the old word
// contents start at zero in simulation and are never reset

`timescale 1ns/1ps

module mem_1r1w_pipelined import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,

  // write port
  input  logic                      ena,
  input  logic [TBL_ADDR_WIDTH-1:0] addra,
  input  logic [LINE_SIZE-1:0]      dina,

  // read port
  input  logic                      enb,
  input  logic [TBL_ADDR_WIDTH-1:0] addrb,
  output logic [LINE_SIZE-1:0]      doutb,
  output logic                      doutb_valid
);

  logic [LINE_SIZE-1:0] mem [TBL_DEPTH];

  // read register, first stage behind the array
  logic [LINE_SIZE-1:0] rd_q;

  // output stages, payload only
  logic [LINE_SIZE-1:0] stage_q [RAM_PIPELINE];

  // vld_q[0] qualifies rd_q, vld_q[i+1] qualifies stage_q[i]
  logic [RAM_PIPELINE:0] vld_q;

  initial begin
    for (int k = 0; k < TBL_DEPTH; k++) begin
      mem[k] = '0;
    end
  end

  // array write and read register
  always @(posedge clk) begin
    if (ena)
      mem[addra] <= dina;
    if (enb)
      rd_q <= mem[addrb];
  end

  // each stage loads only when the stage ahead holds a live word
  always_ff @(posedge clk) begin
    if (vld_q[0])
      stage_q[0] <= rd_q;
    for (int i = 1; i < RAM_PIPELINE; i++) begin
      if (vld_q[i])
        stage_q[i] <= stage_q[i-1];
    end
  end

  // valid shifts alongside the data
  always_ff @(posedge clk) begin
    if (rst)
      vld_q <= '0;
    else
      vld_q <= {vld_q[RAM_PIPELINE-1:0], enb};
  end

  assign doutb       = stage_q[RAM_PIPELINE-1];
  assign doutb_valid = vld_q[RAM_PIPELINE];

  // valid chain fully cleared by reset
  a_valid_known : assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(doutb_valid)
  ) else $error("lookup valid unknown after reset");

endmodule

// ==== verilog/mem_2rw.sv ====
// true dual-port scratchpad, both ports on one clock
// a port writes the enabled byte lanes, or reads when no lane is enabled
// read data appears one cycle after the request and holds until the next read
// same-address writes from both ports in one cycle are not allowed
// a read racing a write to the same word on the other port returns
// undefined data
// contents start at zero in simulation and are never reset

`timescale 1ns/1ps

module mem_2rw import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      ena,
  input  logic [BYTES_PER_LINE-1:0] wena,
  input  logic [ADDR_WIDTH-1:0]     addra,
  input  logic [LINE_SIZE-1:0]      dina,
  output logic [LINE_SIZE-1:0]      douta,
  output logic                      rvalida,

  input  logic                      enb,
  input  logic [BYTES_PER_LINE-1:0] wenb,
  input  logic [ADDR_WIDTH-1:0]     addrb,
  input  logic [LINE_SIZE-1:0]      dinb,
  output logic [LINE_SIZE-1:0]      doutb,
  output logic                      rvalidb
);

  logic [LINE_SIZE-1:0] mem [SP_DEPTH];

  // read registers, payload only
  logic [LINE_SIZE-1:0] douta_q;
  logic [LINE_SIZE-1:0] doutb_q;

  // enabled with no byte lanes means read
  logic rd_a;
  logic rd_b;

  assign rd_a = ena && (wena == '0);
  assign rd_b = enb && (wenb == '0);

  // zero contents for simulation
  initial begin
    for (int k = 0; k < SP_DEPTH; k++) begin
      mem[k] = '0;
    end
  end

  // both ports in one process, same clock
  // ports never hit the same word in one write cycle, so order is free
  always @(posedge clk) begin
    if (ena) begin
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (wena[i])
          mem[addra][i*8 +: 8] <= dina[i*8 +: 8];
      end
    end
    if (enb) begin
      for (int i = 0; i < BYTES_PER_LINE; i++) begin
        if (wenb[i])
          mem[addrb][i*8 +: 8] <= dinb[i*8 +: 8];
      end
    end
    // read-first, old word on a same-port read
    if (rd_a)
      douta_q <= mem[addra];
    if (rd_b)
      doutb_q <= mem[addrb];
  end

  // read-valid pulses, one per read
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalida <= 1'b0;
      rvalidb <= 1'b0;
    end else begin
      rvalida <= rd_a;
      rvalidb <= rd_b;
    end
  end

  assign douta = douta_q;
  assign doutb = doutb_q;

  // core and DMA masters must keep their write addresses apart
  a_no_same_addr_write : assert property (
    @(posedge clk) disable iff (rst)
    !(ena && enb && (wena != '0) && (wenb != '0) && (addra == addrb))
  ) else $error("both scratchpad ports write address %0h", addra);

endmodule

// ==== verilog/mem_pkg.sv ====
// shared widths, depths and opcodes for the core local memory block
// single clock domain, all memories sized from the constants below
// core and DMA scratchpad addresses share ADDR_WIDTH
// lookup table is smaller and indexed by the low TBL_ADDR_WIDTH bits

package mem_pkg;

  // bytes per memory word
  localparam int BYTES_PER_LINE = 4;

  // bits per word, one byte lane per enable bit
  localparam int LINE_SIZE = 8 * BYTES_PER_LINE;

  // scratchpad word address, 256 words
  localparam int ADDR_WIDTH = 8;
  localparam int SP_DEPTH   = 1 << ADDR_WIDTH;

  // lookup table address, 64 entries
  localparam int TBL_ADDR_WIDTH = 6;
  localparam int TBL_DEPTH      = 1 << TBL_ADDR_WIDTH;

  // output register stages behind the table read register
  // total lookup latency is RAM_PIPELINE + 1 cycles
  localparam int RAM_PIPELINE = 2;

  // core opcodes
  typedef enum logic [1:0] {
    // idle cycle
    OP_NOP    = 2'd0,
    // scratchpad word read
    OP_READ   = 2'd1,
    // scratchpad byte-enabled write
    OP_WRITE  = 2'd2,
    // table read, range checked
    OP_LOOKUP = 2'd3
  } core_op_t;

endpackage
